/* Makefile */
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* cache/cache_array.sv */
// ------------------------------
// direct-mapped data and tag RAMs with
// valid bits, synchronous read, one write port
// ------------------------------
module cache_array
  import cache_pkg::*;
(
  input  logic              CPU_CLK,
  input  logic              RST,
  input  logic [idx_w-1:0]  rd_idx,
  input  logic              wr_en,
  input  logic [idx_w-1:0]  wr_idx,
  input  logic [ctag_w-1:0] wr_tag,
  input  logic [31:0]       wr_data,
  input  logic              inval,
  output logic [ctag_w-1:0] rd_tag,
  output logic [31:0]       rd_data,
  output logic              rd_valid
);

  logic [31:0]       data_mem [cache_depth];
  logic [ctag_w-1:0] tag_mem  [cache_depth];
  logic [cache_depth-1:0] valid;

  // ------------------------------
  // write side
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

  // invalidate wins over a fill at the same index
  always_ff @(posedge CPU_CLK)
  begin
    if (inval)
      valid[wr_idx] <= 1'b0;
    else if (wr_en)
      valid[wr_idx] <= 1'b1;
  end

  // ------------------------------
  // read side one cycle after rd_idx
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    rd_data <= data_mem[rd_idx];
    rd_tag  <= tag_mem[rd_idx];
  end

  // valid flag of the line read out
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      rd_valid <= 1'b0;
    else
      rd_valid <= valid[rd_idx];
  end

endmodule

/* cache/cache_ctrl.sv */
// ------------------------------
// cache controller FSM for lookup, memory access,
// line fill, write-through and reset sweep
// ------------------------------
module cache_ctrl
  import cache_pkg::*;
(
  input  logic              CPU_CLK,
  input  logic              RST,
  input  logic              cpu_req,
  input  logic              cpu_we,
  input  logic [31:0]       cpu_addr,
  input  logic [31:0]       cpu_wdata,
  input  logic              cache_inhibit,
  input  logic [31:0]       paddr,
  input  logic              fault,
  input  logic [ctag_w-1:0] rd_tag,
  input  logic [31:0]       rd_data,
  input  logic              rd_valid,
  input  logic              mem_ack,
  input  logic [31:0]       mem_rdata,
  output logic              cpu_done,
  output logic              cpu_fault,
  output logic [31:0]       cpu_rdata,
  output logic              tlb_busy,
  output logic [idx_w-1:0]  rd_idx,
  output logic              wr_en,
  output logic              inval,
  output logic [idx_w-1:0]  wr_idx,
  output logic [ctag_w-1:0] wr_tag,
  output logic [31:0]       wr_data,
  output logic              mem_req,
  output logic              mem_we,
  output logic [31:0]       mem_addr,
  output logic [31:0]       mem_wdata
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  cycle_kind_t kind_q;

  logic             sweep_on;
  logic             sweep_on_nxt;
  logic [idx_w-1:0] sweep_cnt;

  logic [idx_w-1:0]  line_idx;
  logic [ctag_w-1:0] line_tag;
  logic [31:0]       line_data;
  logic              line_upd;
  logic              line_kill;
  logic              hit;

  // arrays read straight from the CPU address
  assign rd_idx = cpu_addr[2 +: idx_w];

  assign hit = rd_valid && (rd_tag == paddr[addr_w-1 -: ctag_w]) && !cache_inhibit;

  // sweep runs once over all indices after reset
  assign sweep_on_nxt = sweep_on && (sweep_cnt != idx_w'(cache_depth - 1));

  // ------------------------------
  // next state
  // ------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:
        if (cpu_req && !sweep_on)
          state_nxt = st_lookup;
      st_lookup:
        if (fault)
          state_nxt = st_respond;
        else if (kind_q == cyc_write)
          state_nxt = st_mem_write;
        else if (hit)
          state_nxt = st_respond;
        else
          state_nxt = st_mem_read;
      st_mem_read, st_mem_write:
        if (mem_ack)
          state_nxt = st_respond;
      default:
        state_nxt = st_idle;
    endcase
  end

  // ------------------------------
  // control registers
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state     <= st_idle;
      kind_q    <= cyc_read;
      sweep_on  <= 1'b1;
      sweep_cnt <= '0;
      tlb_busy  <= 1'b0;
      cpu_done  <= 1'b0;
      cpu_fault <= 1'b0;
      mem_req   <= 1'b0;
      mem_we    <= 1'b0;
      line_upd  <= 1'b0;
      line_kill <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      sweep_on <= sweep_on_nxt;
      tlb_busy <= sweep_on_nxt || (state_nxt != st_idle);
      if (sweep_on)
        sweep_cnt <= sweep_cnt + 1'b1;
      case (state)
        st_idle:
          kind_q <= cpu_we ? cyc_write : cyc_read;
        st_lookup:
        begin
          if (fault)
          begin
            cpu_done  <= 1'b1;
            cpu_fault <= 1'b1;
          end
          else if (kind_q == cyc_write)
          begin
            mem_req   <= 1'b1;
            mem_we    <= 1'b1;
            // inhibited write drops the line instead of updating it
            line_upd  <= !cache_inhibit;
            line_kill <= cache_inhibit;
          end
          else if (hit)
            cpu_done <= 1'b1;
          else
          begin
            mem_req  <= 1'b1;
            line_upd <= 1'b1;
          end
        end
        st_mem_read, st_mem_write:
          if (mem_ack)
          begin
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
            cpu_done <= 1'b1;
          end
        default:
        begin
          cpu_done  <= 1'b0;
          cpu_fault <= 1'b0;
          line_upd  <= 1'b0;
          line_kill <= 1'b0;
        end
      endcase
    end
  end

  // ------------------------------
  // request and line payload
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (state == st_lookup)
    begin
      line_idx  <= paddr[2 +: idx_w];
      line_tag  <= paddr[addr_w-1 -: ctag_w];
      mem_addr  <= {2'b00, paddr[addr_w-1:2]};
      line_data <= cpu_wdata;
      cpu_rdata <= rd_data;
    end
    else if (state == st_mem_read && mem_ack)
    begin
      line_data <= mem_rdata;
      cpu_rdata <= mem_rdata;
    end
  end

  assign mem_wdata = line_data;

  // line written in the cycle of cpu_done
  assign wr_en   = (state == st_respond) && line_upd;
  assign inval   = sweep_on || ((state == st_respond) && line_kill);
  assign wr_idx  = sweep_on ? sweep_cnt : line_idx;
  assign wr_tag  = line_tag;
  assign wr_data = line_data;

endmodule

/* cache/tlb.sv */
// ------------------------------
// TLB with a virtual tag and page number per entry
// plus address translation and fault detection
// ------------------------------
module tlb
  import cache_pkg::*;
(
  input  logic                 CPU_CLK,
  input  logic [addr_w-1:0]    vaddr,
  input  logic                 vmem_act,
  input  logic                 tlb_we,
  input  logic [tlb_idx_w-1:0] tlb_addr,
  input  logic [31:0]          tlb_wdata,
  output logic [addr_w-1:0]    paddr,
  output logic                 fault
);

  logic [vtag_w-1:0] vtag_mem [tlb_depth];
  logic [ppn_w-1:0]  ppn_mem  [tlb_depth];

  logic [vtag_w-1:0] rd_vtag;
  logic [ppn_w-1:0]  rd_ppn;
  logic [addr_w-1:0] vaddr_q;
  logic [tlb_idx_w-1:0] rd_idx;

  // entry selected by vaddr[17:10]
  assign rd_idx = vaddr[addr_w-vtag_w-1 -: tlb_idx_w];

  // ------------------------------
  // entry write port
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (tlb_we)
    begin
      vtag_mem[tlb_addr] <= tlb_wdata[tlb_vtag_lsb +: vtag_w];
      ppn_mem[tlb_addr]  <= tlb_wdata[ppn_w-1:0];
    end
  end

  // ------------------------------
  // lookup registered together with the address
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    rd_vtag <= vtag_mem[rd_idx];
    rd_ppn  <= ppn_mem[rd_idx];
    vaddr_q <= vaddr;
  end

  // page number replaces the upper bits when translating
  always_comb
  begin
    if (vmem_act)
      paddr = {rd_ppn, vaddr_q[addr_w-ppn_w-1:0]};
    else
      paddr = vaddr_q;
  end

  // stored virtual tag must match vaddr[31:18]
  assign fault = vmem_act && (rd_vtag != vaddr_q[addr_w-1 -: vtag_w]);

endmodule

/* common/cache_pkg.sv */
// ------------------------------
// shared widths, depths and enums of the
// virtually addressed cache and its TLB
// ------------------------------
package cache_pkg;

  // ------------------------------
  // address fields
  // ------------------------------
  localparam int addr_w    = 32;
  // cache index is paddr[9:2], tag is paddr[31:10]
  localparam int idx_w     = 8;
  localparam int ctag_w    = 22;
  // TLB index is vaddr[17:10], virtual tag is vaddr[31:18]
  localparam int tlb_idx_w = 8;
  localparam int vtag_w    = 14;
  localparam int ppn_w     = 14;

  // position of the virtual tag within a TLB write word
  localparam int tlb_vtag_lsb = 16;

  // ------------------------------
  // array depths
  // ------------------------------
  localparam int cache_depth = 256;
  localparam int tlb_depth   = 256;

  // controller states
  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_mem_read,
    st_mem_write,
    st_respond
  } ctrl_state_t;

  // latched request type
  typedef enum logic {
    cyc_read,
    cyc_write
  } cycle_kind_t;

endpackage

/* dv/cache_assert.sv */
// ------------------------------
// handshake assertions on the cache controller
// ------------------------------
module cache_assert
  import cache_pkg::*;
(
  input logic        CPU_CLK,
  input logic        RST,
  input logic        mem_req,
  input logic        mem_ack,
  input logic        cpu_done,
  input logic        fault,
  input ctrl_state_t state
);
  timeunit 1ns;
  timeprecision 100ps;

  // request held until acknowledged
  a_req_hold: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_req && !mem_ack |=> mem_req)
    else $error("mem_req dropped before mem_ack");

  // completion is a single pulse
  a_done_pulse: assert property (@(posedge CPU_CLK) disable iff (!RST)
    cpu_done |=> !cpu_done)
    else $error("cpu_done held for more than one cycle");

  // a faulting lookup never reaches memory
  a_fault_nomem: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (state == st_lookup) && fault |=> !mem_req)
    else $error("mem_req raised after a TLB fault");

endmodule

bind cache_ctrl cache_assert u_assert (
  .CPU_CLK  (CPU_CLK),
  .RST      (RST),
  .mem_req  (mem_req),
  .mem_ack  (mem_ack),
  .cpu_done (cpu_done),
  .fault    (fault),
  .state    (state)
);

/* dv/cache_tb.sv */
// ------------------------------
// cache testbench driving a stimulus table
// checked against memory and TLB models
// ------------------------------
module cache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {op_tlb, op_read, op_write} op_t;

  typedef struct packed {
    op_t         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic        vmem;
    logic        inh;
    logic        exp_fault;
    logic        exp_mem;
  } step_t;

  localparam int done_timeout  = 50;
  localparam int sweep_timeout = 400;

  localparam logic [31:0] addr_a    = 32'h0000_1230;
  localparam logic [31:0] addr_b    = 32'h0000_2040;
  localparam logic [13:0] vtag_ok   = 14'h0123;
  localparam logic [13:0] ppn_ok    = 14'h0456;
  localparam logic [7:0]  tlb_slot  = 8'h05;
  localparam logic [31:0] vaddr_ok  = {vtag_ok, tlb_slot, 10'h040};
  localparam logic [31:0] vaddr_bad = {14'h0124, tlb_slot, 10'h040};
  localparam logic [31:0] tlb_word  = {2'b00, vtag_ok, 2'b00, ppn_ok};

  logic        CPU_CLK, RST;
  logic        cpu_req, cpu_we, cpu_done, cpu_fault;
  logic [31:0] cpu_addr, cpu_wdata, cpu_rdata;
  logic        vmem_act, cache_inhibit, tlb_we, tlb_busy;
  logic [7:0]  tlb_addr;
  logic [31:0] tlb_wdata;
  logic        mem_req, mem_we, mem_ack;
  logic [31:0] mem_addr, mem_wdata, mem_rdata;

  // models of memory contents and TLB page numbers
  logic [31:0] mem_image [logic [31:0]];
  logic [13:0] tlb_ppn_m [256];
  step_t       steps [$];

  int          mem_cnt = 0;
  logic [31:0] seen_addr, seen_wdata;
  logic        seen_we;

  cache_top u_dut (.*);

  mem_model u_mem (.*);

  initial
  begin
    CPU_CLK = 1'b0;
    forever #2 CPU_CLK = ~CPU_CLK;
  end

  // record every completed memory handshake
  always @(negedge CPU_CLK)
  begin
    if (mem_req && mem_ack)
    begin
      mem_cnt    = mem_cnt + 1;
      seen_addr  = mem_addr;
      seen_we    = mem_we;
      seen_wdata = mem_wdata;
    end
  end

  function automatic logic [31:0] phys_addr(input logic [31:0] vaddr, input logic vmem);
    if (vmem)
      return {tlb_ppn_m[vaddr[17:10]], vaddr[17:0]};
    else
      return vaddr;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] waddr);
    if (mem_image.exists(waddr))
      return mem_image[waddr];
    else
      return waddr ^ 32'h5A5A_0000;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "wait timed out");
  endtask

  task automatic add_step(input op_t op, input logic [31:0] addr, input logic [31:0] data,
                          input logic vmem, input logic inh, input logic flt, input logic mem);
    steps.push_back(step_t'{op, addr, data, vmem, inh, flt, mem});
  endtask

  task automatic wait_sweep();
    int n;
    n = 0;
    @(negedge CPU_CLK);
    while (tlb_busy !== 1'b1)
    begin
      if (n >= 20)
        stop_on_timeout("start of the valid sweep");
      n++;
      @(negedge CPU_CLK);
    end
    n = 0;
    while (tlb_busy !== 1'b0)
    begin
      if (n >= sweep_timeout)
        stop_on_timeout("end of the valid sweep");
      n++;
      @(negedge CPU_CLK);
    end
  endtask

  task automatic run_tlb(input step_t s);
    @(negedge CPU_CLK);
    check_value("tlb_busy", 32'(tlb_busy), 32'd0);
    @(posedge CPU_CLK);
    tlb_we    <= 1'b1;
    tlb_addr  <= s.addr[7:0];
    tlb_wdata <= s.data;
    @(posedge CPU_CLK);
    tlb_we <= 1'b0;
    tlb_ppn_m[s.addr[7:0]] = s.data[13:0];
  endtask

  task automatic run_access(input step_t s);
    int          lat;
    int          cnt0;
    logic [31:0] waddr;
    logic [31:0] got_rdata;
    logic        got_fault;
    waddr = phys_addr(s.addr, s.vmem) >> 2;
    @(posedge CPU_CLK);
    cnt0          = mem_cnt;
    cpu_req       <= 1'b1;
    cpu_we        <= (s.op == op_write);
    cpu_addr      <= s.addr;
    cpu_wdata     <= s.data;
    vmem_act      <= s.vmem;
    cache_inhibit <= s.inh;
    // count cycles from the first cycle of cpu_req
    lat = 0;
    @(negedge CPU_CLK);
    while (cpu_done !== 1'b1)
    begin
      if (lat >= done_timeout)
        stop_on_timeout("cpu_done");
      lat++;
      @(negedge CPU_CLK);
    end
    got_rdata = cpu_rdata;
    got_fault = cpu_fault;
    @(posedge CPU_CLK);
    cpu_req <= 1'b0;
    cpu_we  <= 1'b0;
    check_value("cpu_fault", 32'(got_fault), 32'(s.exp_fault));
    check_value("mem handshakes", 32'(mem_cnt - cnt0), 32'(s.exp_mem));
    if (s.exp_mem)
    begin
      check_value("mem_addr", seen_addr, waddr);
      check_value("mem_we", 32'(seen_we), 32'(s.op == op_write));
      if (s.op == op_write)
        check_value("mem_wdata", seen_wdata, s.data);
    end
    else
      check_value("cpu_done latency", 32'(lat), 32'd2);
    if (s.op == op_read && !s.exp_fault)
      check_value("cpu_rdata", got_rdata, mem_word(waddr));
    if (s.op == op_write && !s.exp_fault)
      mem_image[waddr] = s.data;
  endtask

  initial
  begin
    RST           = 1'b0;
    cpu_req       = 1'b0;
    cpu_we        = 1'b0;
    cpu_addr      = '0;
    cpu_wdata     = '0;
    vmem_act      = 1'b0;
    cache_inhibit = 1'b0;
    tlb_we        = 1'b0;
    tlb_addr      = '0;
    tlb_wdata     = '0;

    // ------------------------------
    // op, addr, data, vmem, inhibit, fault, mem
    // ------------------------------
    add_step(op_read,  addr_a,    32'h0,         1'b0, 1'b0, 1'b0, 1'b1);
    add_step(op_read,  addr_a,    32'h0,         1'b0, 1'b0, 1'b0, 1'b0);
    add_step(op_write, addr_b,    32'hCAFE_F00D, 1'b0, 1'b0, 1'b0, 1'b1);
    add_step(op_read,  addr_b,    32'h0,         1'b0, 1'b0, 1'b0, 1'b0);
    add_step(op_write, addr_a,    32'h1111_2222, 1'b0, 1'b0, 1'b0, 1'b1);
    add_step(op_read,  addr_a,    32'h0,         1'b0, 1'b0, 1'b0, 1'b0);
    add_step(op_tlb,   32'(tlb_slot), tlb_word,  1'b0, 1'b0, 1'b0, 1'b0);
    add_step(op_read,  vaddr_ok,  32'h0,         1'b1, 1'b0, 1'b0, 1'b1);
    add_step(op_read,  vaddr_ok,  32'h0,         1'b1, 1'b0, 1'b0, 1'b0);
    add_step(op_read,  vaddr_bad, 32'h0,         1'b1, 1'b0, 1'b1, 1'b0);
    // inhibited accesses always go to memory
    add_step(op_read,  addr_a,    32'h0,         1'b0, 1'b1, 1'b0, 1'b1);
    add_step(op_read,  addr_a,    32'h0,         1'b0, 1'b0, 1'b0, 1'b0);
    add_step(op_write, addr_a,    32'h3333_4444, 1'b0, 1'b1, 1'b0, 1'b1);
    add_step(op_read,  addr_a,    32'h0,         1'b0, 1'b0, 1'b0, 1'b1);
    add_step(op_read,  addr_a,    32'h0,         1'b0, 1'b0, 1'b0, 1'b0);
    add_step(op_write, vaddr_ok,  32'hDEAD_BEEF, 1'b1, 1'b0, 1'b0, 1'b1);
    add_step(op_read,  vaddr_ok,  32'h0,         1'b1, 1'b0, 1'b0, 1'b0);
    add_step(op_write, vaddr_bad, 32'h5555_6666, 1'b1, 1'b0, 1'b1, 1'b0);
    add_step(op_read,  vaddr_ok,  32'h0,         1'b1, 1'b0, 1'b0, 1'b0);

    repeat (9) @(posedge CPU_CLK);
    @(negedge CPU_CLK);
    check_value("cpu_done in reset", 32'(cpu_done), 32'd0);
    check_value("mem_req in reset", 32'(mem_req), 32'd0);
    check_value("mem_we in reset", 32'(mem_we), 32'd0);
    check_value("tlb_busy in reset", 32'(tlb_busy), 32'd0);
    @(posedge CPU_CLK);
    RST <= 1'b1;
    wait_sweep();

    foreach (steps[i])
    begin
      if (steps[i].op == op_tlb)
        run_tlb(steps[i]);
      else
        run_access(steps[i]);
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* dv/mem_model.sv */
// ------------------------------
// behavioural word memory with a random
// acknowledge delay of 1 to 4 cycles
// ------------------------------
module mem_model
(
  input  logic        CPU_CLK,
  input  logic        RST,
  input  logic        mem_req,
  input  logic        mem_we,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  output logic        mem_ack,
  output logic [31:0] mem_rdata
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] store [logic [31:0]];
  integer      seed = 4;
  logic        busy;
  int          wait_cnt;

  always @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      mem_ack   <= 1'b0;
      mem_rdata <= '0;
      busy      <= 1'b0;
      wait_cnt  <= 0;
    end
    else if (mem_ack)
    begin
      mem_ack <= 1'b0;
      busy    <= 1'b0;
    end
    else if (busy)
    begin
      if (wait_cnt <= 1)
      begin
        mem_ack <= 1'b1;
        if (mem_we)
          store[mem_addr] = mem_wdata;
        // unwritten words follow the address pattern
        mem_rdata <= store.exists(mem_addr) ? store[mem_addr] : (mem_addr ^ 32'h5A5A_0000);
      end
      else
        wait_cnt <= wait_cnt - 1;
    end
    else if (mem_req)
    begin
      busy     <= 1'b1;
      wait_cnt <= 1 + ($random(seed) & 3);
    end
  end

endmodule

/* source/cache_top.sv */
// ------------------------------
// virtually addressed cache top level
// ------------------------------
module cache_top
  import cache_pkg::*;
(
  input  logic                 CPU_CLK,
  input  logic                 RST,
  input  logic                 cpu_req,
  input  logic                 cpu_we,
  input  logic [31:0]          cpu_addr,
  input  logic [31:0]          cpu_wdata,
  output logic                 cpu_done,
  output logic [31:0]          cpu_rdata,
  output logic                 cpu_fault,
  input  logic                 vmem_act,
  input  logic                 cache_inhibit,
  input  logic                 tlb_we,
  input  logic [tlb_idx_w-1:0] tlb_addr,
  input  logic [31:0]          tlb_wdata,
  output logic                 tlb_busy,
  output logic                 mem_req,
  output logic                 mem_we,
  output logic [31:0]          mem_addr,
  output logic [31:0]          mem_wdata,
  input  logic                 mem_ack,
  input  logic [31:0]          mem_rdata
);

  // translation result
  logic [addr_w-1:0] paddr;
  logic              fault;

  // array read and write ports
  logic [idx_w-1:0]  rd_idx;
  logic [ctag_w-1:0] rd_tag;
  logic [31:0]       rd_data;
  logic              rd_valid;
  logic              wr_en;
  logic              inval;
  logic [idx_w-1:0]  wr_idx;
  logic [ctag_w-1:0] wr_tag;
  logic [31:0]       wr_data;

  cache_ctrl u_ctrl (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .cpu_req       (cpu_req),
    .cpu_we        (cpu_we),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cache_inhibit (cache_inhibit),
    .paddr         (paddr),
    .fault         (fault),
    .rd_tag        (rd_tag),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .cpu_done      (cpu_done),
    .cpu_fault     (cpu_fault),
    .cpu_rdata     (cpu_rdata),
    .tlb_busy      (tlb_busy),
    .rd_idx        (rd_idx),
    .wr_en         (wr_en),
    .inval         (inval),
    .wr_idx        (wr_idx),
    .wr_tag        (wr_tag),
    .wr_data       (wr_data),
    .mem_req       (mem_req),
    .mem_we        (mem_we),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata)
  );

  cache_array u_array (
    .CPU_CLK  (CPU_CLK),
    .RST      (RST),
    .rd_idx   (rd_idx),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_tag   (wr_tag),
    .wr_data  (wr_data),
    .inval    (inval),
    .rd_tag   (rd_tag),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  // same virtual address as the cache index
  tlb u_tlb (
    .CPU_CLK   (CPU_CLK),
    .vaddr     (cpu_addr),
    .vmem_act  (vmem_act),
    .tlb_we    (tlb_we),
    .tlb_addr  (tlb_addr),
    .tlb_wdata (tlb_wdata),
    .paddr     (paddr),
    .fault     (fault)
  );

endmodule

/* src.f */
common/cache_pkg.sv
cache/cache_array.sv
cache/tlb.sv
cache/cache_ctrl.sv
source/cache_top.sv
dv/mem_model.sv
dv/cache_assert.sv
dv/cache_tb.sv
